//--- source/koa_defs.svh
// Karatsuba multiplier widths
`ifndef KOA_DEFS_SVH
`define KOA_DEFS_SVH

// ======================================================================
// Significand and product sizes
// ======================================================================

// Unsigned significand width of one operand
// Single precision with the hidden bit
`define KOA_SW 24

// Full product width, no rounding or truncation
`define KOA_PW (2 * `KOA_SW)

`endif

//--- source/koa_pkg.sv
// Multiplier shared types
`default_nettype none

`include "koa_defs.svh"

package koa_pkg;

    // Command opcodes
    typedef enum logic {
        OP_MUL = 1'b0,  // a times b
        OP_SQR = 1'b1   // a times a, b unused
    } mul_op_t;

    // Owner of the result now held in the multiplier
    typedef enum logic [1:0] {
        OWN_NONE = 2'd0,
        OWN_P0   = 2'd1,
        OWN_P1   = 2'd2
    } owner_t;

    // One requester command, 49 bits
    typedef struct packed {
        mul_op_t            op;
        logic [`KOA_SW-1:0] a;
        logic [`KOA_SW-1:0] b;
    } mul_cmd_t;

    // Operand word on the shared multiplier bus
    typedef struct packed {
        logic [`KOA_SW-1:0] a;
        logic [`KOA_SW-1:0] b;
    } operand_pair_t;

    typedef logic [`KOA_PW-1:0] product_t;

endpackage

`default_nettype wire

//--- source/koa_split_mult.sv
// One-level Karatsuba multiplier
`timescale 1ns/100ps
`default_nettype none

`include "koa_defs.svh"

module koa_split_mult #(
    parameter int SW = `KOA_SW
) (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         load_i,
    input  wire koa_pkg::operand_pair_t opnd_i,
    output koa_pkg::product_t           product_o
);
    import koa_pkg::*;

    // High part is the narrower half for odd widths
    localparam int HW = SW / 2;
    localparam int LW = SW - HW;
    localparam int PW = 2 * SW;

    // Operands resized to this instance's width
    logic [SW-1:0]     a_w;
    logic [SW-1:0]     b_w;

    // Split halves
    logic [HW-1:0]     a_hi;
    logic [HW-1:0]     b_hi;
    logic [LW-1:0]     a_lo;
    logic [LW-1:0]     b_lo;

    // Half sums, one carry bit each
    logic [LW:0]       a_sum;
    logic [LW:0]       b_sum;

    // Sub-products
    logic [2*HW-1:0]   q_hi;
    logic [2*LW-1:0]   q_lo;
    logic [2*LW+1:0]   q_sum;
    logic [2*LW+1:0]   q_mid;

    logic [PW-1:0]     total;
    product_t          prod_q;

    // ======================================================================
    // Operand split
    // ======================================================================
    assign a_w  = SW'(opnd_i.a);
    assign b_w  = SW'(opnd_i.b);

    assign a_hi = a_w[SW-1 -: HW];
    assign b_hi = b_w[SW-1 -: HW];
    assign a_lo = a_w[LW-1:0];
    assign b_lo = b_w[LW-1:0];

    // Carry out of the half sum kept for the middle product
    assign a_sum = {1'b0, a_lo} + (LW+1)'(a_hi);
    assign b_sum = {1'b0, b_lo} + (LW+1)'(b_hi);

    // ======================================================================
    // Three products and recombination
    // ======================================================================
    assign q_hi  = a_hi * b_hi;
    assign q_lo  = a_lo * b_lo;
    assign q_sum = a_sum * b_sum;

    // Cross terms a_hi*b_lo + a_lo*b_hi, never negative
    assign q_mid = q_sum - (2*LW+2)'(q_lo) - (2*LW+2)'(q_hi);

    // High term at 2*LW, middle term at LW
    assign total = (PW'(q_hi) << (2 * LW))
                 + (PW'(q_mid) << LW)
                 + PW'(q_lo);

    // Result register, loaded on strobe
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prod_q <= '0;
        end else if (load_i) begin
            prod_q <= product_t'(total);
        end
    end

    assign product_o = prod_q;

endmodule

`default_nettype wire

//--- source/koa_port.sv
// Multiplier requester port
`timescale 1ns/100ps
`default_nettype none

module koa_port (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         start_i,
    input  wire koa_pkg::mul_cmd_t      cmd_i,
    output logic                        busy_o,
    output logic                        done_o,
    output koa_pkg::product_t           product_o,
    output logic                        pend_o,
    output koa_pkg::operand_pair_t      opnd_o,
    input  wire                         grant_i,
    input  wire                         rsp_valid_i,
    input  wire koa_pkg::product_t      rsp_product_i
);
    import koa_pkg::*;

    // Request FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // free for a new command
        ST_PEND = 2'd1,  // waiting for grant
        ST_WAIT = 2'd2   // in the multiplier, waiting for response
    } port_state_t;

    port_state_t   state_q;
    logic          done_q;
    logic          accept_w;
    logic          finish_w;
    operand_pair_t opnd_q;
    product_t      product_q;

    // Start only counts when idle
    assign accept_w = (state_q == ST_IDLE) && start_i;
    assign finish_w = (state_q == ST_WAIT) && rsp_valid_i;

    // ======================================================================
    // Control
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= finish_w;
            case (state_q)
                ST_IDLE: if (accept_w) state_q <= ST_PEND;
                ST_PEND: if (grant_i) state_q <= ST_WAIT;
                ST_WAIT: if (finish_w) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Command and result payload
    always_ff @(posedge clk) begin
        if (accept_w) begin
            opnd_q.a <= cmd_i.a;
            // Square resolved here, multiplier sees no opcode
            opnd_q.b <= (cmd_i.op == OP_SQR) ? cmd_i.a : cmd_i.b;
        end
        if (finish_w) begin
            product_q <= rsp_product_i;
        end
    end

    assign busy_o    = (state_q != ST_IDLE);
    assign pend_o    = (state_q == ST_PEND);
    assign done_o    = done_q;
    assign product_o = product_q;
    assign opnd_o    = opnd_q;

endmodule

`default_nettype wire

//--- source/koa_arbiter.sv
// Round-robin multiplier arbiter
`timescale 1ns/100ps
`default_nettype none

module koa_arbiter (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire [1:0]                   pend_i,
    input  wire koa_pkg::operand_pair_t opnd0_i,
    input  wire koa_pkg::operand_pair_t opnd1_i,
    output logic [1:0]                  grant_o,
    output logic                        load_o,
    output koa_pkg::operand_pair_t      opnd_o,
    input  wire koa_pkg::product_t      product_i,
    output logic [1:0]                  rsp_valid_o,
    output koa_pkg::product_t           rsp_product_o
);
    import koa_pkg::*;

    // Last winner, high means port 1
    logic   last_q;

    logic   pick0_w;
    logic   pick1_w;

    // Owner of the product the multiplier shows next cycle
    owner_t owner_d;
    owner_t owner_q;

    // ======================================================================
    // Winner selection
    // ======================================================================

    // Port 0 wins alone, or on a tie when port 1 had the last grant
    assign pick0_w = pend_i[0] && (!pend_i[1] || last_q);
    assign pick1_w = pend_i[1] && !pick0_w;

    // Grant and load in the same cycle as pend
    assign grant_o = {pick1_w, pick0_w};
    assign load_o  = pick0_w || pick1_w;

    // Winner's operands onto the shared bus
    assign opnd_o  = pick1_w ? opnd1_i : opnd0_i;

    always_comb begin
        if (pick0_w) begin
            owner_d = OWN_P0;
        end else if (pick1_w) begin
            owner_d = OWN_P1;
        end else begin
            owner_d = OWN_NONE;
        end
    end

    // ======================================================================
    // Grant history and result steering
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            // Port 0 preferred first
            last_q  <= 1'b1;
            owner_q <= OWN_NONE;
        end else begin
            owner_q <= owner_d;
            if (load_o) begin
                last_q <= pick1_w;
            end
        end
    end

    // Response one cycle after load, only to the recorded owner
    assign rsp_valid_o[0] = (owner_q == OWN_P0);
    assign rsp_valid_o[1] = (owner_q == OWN_P1);

    // Product shared, qualified by rsp_valid_o
    assign rsp_product_o  = product_i;

endmodule

`default_nettype wire

//--- source/koa_mult_top.sv
// Shared significand multiplier top
`timescale 1ns/100ps
`default_nettype none

module koa_mult_top (
    input  wire                         clk,
    input  wire                         rst_n_i,
    input  wire                         start0_i,
    input  wire                         start1_i,
    input  wire koa_pkg::mul_cmd_t      cmd0_i,
    input  wire koa_pkg::mul_cmd_t      cmd1_i,
    output logic                        busy0_o,
    output logic                        busy1_o,
    output logic                        done0_o,
    output logic                        done1_o,
    output koa_pkg::product_t           product0_o,
    output koa_pkg::product_t           product1_o
);
    import koa_pkg::*;

    // Port to arbiter
    logic [1:0]    pend;
    logic [1:0]    grant;
    logic [1:0]    rsp_valid;
    operand_pair_t opnd0;
    operand_pair_t opnd1;
    product_t      rsp_product;

    // Arbiter to multiplier
    logic          load;
    operand_pair_t bus_opnd;
    product_t      mult_product;

    // ======================================================================
    // Requester ports
    // ======================================================================
    koa_port u_port0 (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .start_i       (start0_i),
        .cmd_i         (cmd0_i),
        .busy_o        (busy0_o),
        .done_o        (done0_o),
        .product_o     (product0_o),
        .pend_o        (pend[0]),
        .opnd_o        (opnd0),
        .grant_i       (grant[0]),
        .rsp_valid_i   (rsp_valid[0]),
        .rsp_product_i (rsp_product)
    );

    koa_port u_port1 (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .start_i       (start1_i),
        .cmd_i         (cmd1_i),
        .busy_o        (busy1_o),
        .done_o        (done1_o),
        .product_o     (product1_o),
        .pend_o        (pend[1]),
        .opnd_o        (opnd1),
        .grant_i       (grant[1]),
        .rsp_valid_i   (rsp_valid[1]),
        .rsp_product_i (rsp_product)
    );

    // ======================================================================
    // Arbiter and shared multiplier
    // ======================================================================
    koa_arbiter u_arbiter (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .pend_i        (pend),
        .opnd0_i       (opnd0),
        .opnd1_i       (opnd1),
        .grant_o       (grant),
        .load_o        (load),
        .opnd_o        (bus_opnd),
        .product_i     (mult_product),
        .rsp_valid_o   (rsp_valid),
        .rsp_product_o (rsp_product)
    );

    koa_split_mult u_mult (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .load_i    (load),
        .opnd_i    (bus_opnd),
        .product_o (mult_product)
    );

endmodule

`default_nettype wire

//--- test/tb_koa_mult_top.sv
// Shared multiplier testbench
`timescale 1ns/100ps
`default_nettype none

`include "koa_defs.svh"

module tb_koa_mult_top;
    import koa_pkg::*;

    // One start lands while busy and returns no product
    localparam int N_CMDS     = 448;
    localparam int N_PRODUCTS = 447;
    localparam int MAX_CYCLES = 20 * N_CMDS + 100;

    logic        clk;
    logic        rst_n;
    logic        start0;
    logic        start1;
    mul_cmd_t    cmd0;
    mul_cmd_t    cmd1;
    logic        busy0;
    logic        busy1;
    logic        done0;
    logic        done1;
    product_t    product0;
    product_t    product1;

    // Expected products per channel in issue order
    product_t    exp0[$];
    product_t    exp1[$];
    int          n_done0 = 0;
    int          n_done1 = 0;
    int          cycle_cnt = 0;
    logic [15:0] lfsr_q;
    logic [`KOA_SW-1:0] corner [6];
    mul_cmd_t    stream0 [200];
    mul_cmd_t    stream1 [200];

    koa_mult_top dut_i (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .start0_i   (start0),
        .start1_i   (start1),
        .cmd0_i     (cmd0),
        .cmd1_i     (cmd1),
        .busy0_o    (busy0),
        .busy1_o    (busy1),
        .done0_o    (done0),
        .done1_o    (done1),
        .product0_o (product0),
        .product1_o (product1)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ======================================================================
    // Stimulus and reference model
    // ======================================================================

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic [`KOA_SW-1:0] rand_bits(input int n);
        logic [`KOA_SW-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[`KOA_SW-2:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic mul_cmd_t rand_cmd();
        mul_cmd_t           c;
        logic [`KOA_SW-1:0] op_bit;
        op_bit = rand_bits(1);
        c.op   = op_bit[0] ? OP_SQR : OP_MUL;
        c.a    = rand_bits(`KOA_SW);
        c.b    = rand_bits(`KOA_SW);
        return c;
    endfunction

    // Full width product where a square ignores b
    function automatic product_t ref_product(input mul_cmd_t c);
        logic [`KOA_PW-1:0] a_x;
        logic [`KOA_PW-1:0] b_x;
        a_x = {{`KOA_SW{1'b0}}, c.a};
        b_x = (c.op == OP_SQR) ? a_x : {{`KOA_SW{1'b0}}, c.b};
        return a_x * b_x;
    endfunction

    function automatic owner_t finished_owner();
        if (done0 && !done1) return OWN_P0;
        if (done1 && !done0) return OWN_P1;
        return OWN_NONE;
    endfunction

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_product(input product_t got, input product_t want, input string what);
        if (got !== want) begin
            $display("[FAIL] %0t: %s product %h, expected %h", $time, what, got, want);
            stop_run();
        end
    endtask

    task automatic check_order(input owner_t got, input owner_t want);
        if (got !== want) begin
            $display("[FAIL] %0t: finished %s, expected %s", $time, got.name(), want.name());
            stop_run();
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n  <= 1'b0;
        start0 <= 1'b0;
        start1 <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // One command that returns once busy has fallen
    task automatic issue(input int ch, input mul_cmd_t c);
        @(posedge clk);
        if (ch == 0) begin
            start0 <= 1'b1;
            cmd0   <= c;
            exp0.push_back(ref_product(c));
        end else begin
            start1 <= 1'b1;
            cmd1   <= c;
            exp1.push_back(ref_product(c));
        end
        @(posedge clk);
        if (ch == 0) begin
            start0 <= 1'b0;
        end else begin
            start1 <= 1'b0;
        end
        do begin
            @(negedge clk);
        end while ((ch == 0) ? busy0 : busy1);
    endtask

    task automatic run_stream(input int ch);
        for (int n = 0; n < 200; n++) begin
            issue(ch, (ch == 0) ? stream0[n] : stream1[n]);
        end
    endtask

    // ======================================================================
    // Result compare with one process per channel
    // ======================================================================
    always @(negedge clk) begin
        if (done0) begin
            if (exp0.size() == 0) begin
                $display("Channel 0 signalled done with no command outstanding");
                stop_run();
            end else begin
                check_product(product0, exp0.pop_front(), "channel 0");
                n_done0++;
            end
        end
    end

    always @(negedge clk) begin
        if (done1) begin
            if (exp1.size() == 0) begin
                $display("Channel 1 signalled done with no command outstanding");
                stop_run();
            end else begin
                check_product(product1, exp1.pop_front(), "channel 1");
                n_done1++;
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        mul_cmd_t c;
        mul_cmd_t c2;
        owner_t   want;
        rst_n  = 1'b0;
        start0 = 1'b0;
        start1 = 1'b0;
        cmd0   = '0;
        cmd1   = '0;
        lfsr_q = 16'd22705;
        // Zero, one, all ones, then half sums that carry
        corner = '{24'h000000, 24'h000001, 24'hFFFFFF, 24'h800800, 24'hFFF001, 24'h00FFFF};
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Idle outputs after reset and lone multiply latency
        @(negedge clk);
        if (busy0 || busy1 || done0 || done1) begin
            $display("Busy or done outputs are not low after reset");
            stop_run();
        end
        c    = rand_cmd();
        c.op = OP_MUL;
        @(posedge clk);
        start0 <= 1'b1;
        cmd0   <= c;
        exp0.push_back(ref_product(c));
        for (int k = 1; k <= 3; k++) begin
            @(posedge clk);
            start0 <= 1'b0;
            @(negedge clk);
            want = (k == 3) ? OWN_P0 : OWN_NONE;
            check_order(finished_owner(), want);
        end

        // Square on channel 1 with a random b
        c    = rand_cmd();
        c.op = OP_SQR;
        issue(1, c);

        // Corner operands for both opcodes
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                c.op = OP_MUL;
                c.a  = corner[i];
                c.b  = corner[j];
                issue((i + j) % 2, c);
            end
            c.op = OP_SQR;
            c.a  = corner[i];
            c.b  = rand_bits(`KOA_SW);
            issue(i % 2, c);
        end

        // Tie after reset serves port 0 first
        apply_reset();
        c  = rand_cmd();
        c2 = rand_cmd();
        @(posedge clk);
        start0 <= 1'b1;
        start1 <= 1'b1;
        cmd0   <= c;
        cmd1   <= c2;
        exp0.push_back(ref_product(c));
        exp1.push_back(ref_product(c2));
        for (int k = 1; k <= 4; k++) begin
            @(posedge clk);
            start0 <= 1'b0;
            start1 <= 1'b0;
            @(negedge clk);
            want = (k == 3) ? OWN_P0 : ((k == 4) ? OWN_P1 : OWN_NONE);
            check_order(finished_owner(), want);
        end

        // Back-to-back random streams on both channels
        for (int n = 0; n < 200; n++) begin
            stream0[n] = rand_cmd();
            stream1[n] = rand_cmd();
        end
        fork
            run_stream(0);
            run_stream(1);
        join

        // Second start while busy must be dropped
        c  = rand_cmd();
        c2 = rand_cmd();
        @(posedge clk);
        start0 <= 1'b1;
        cmd0   <= c;
        exp0.push_back(ref_product(c));
        @(posedge clk);
        cmd0 <= c2;
        @(posedge clk);
        start0 <= 1'b0;
        do begin
            @(negedge clk);
        end while (!done0);
        repeat (4) begin
            @(negedge clk);
            if (busy0) begin
                $display("Channel 0 accepted a start while it was busy");
                stop_run();
            end
        end

        if (exp0.size() == 0 && exp1.size() == 0 && n_done0 + n_done1 == N_PRODUCTS) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Only %0d of %0d products came back", n_done0 + n_done1, N_PRODUCTS);
            stop_run();
        end
    end

endmodule

`default_nettype wire

//--- koa_mult_top.f
+incdir+source
source/koa_pkg.sv
source/koa_split_mult.sv
source/koa_port.sv
source/koa_arbiter.sv
source/koa_mult_top.sv
test/tb_koa_mult_top.sv

//--- Makefile
TOP = tb_koa_mult_top

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f koa_mult_top.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
